//--- verilog.f
otp_lci_pkg.sv
otp_macro.sv
otp_lci.sv
otp_lci_top.sv
tb_otp_lci.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
verilator --binary --timing --assert --top-module tb_otp_lci -f verilog.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_otp_lci > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

//--- tb_otp_lci.sv
module tb_otp_lci;

  timeunit 1ns;
  timeprecision 10ps;

  import otp_lci_pkg::*;

  typedef enum {OpEnable, OpTransition, OpEscalate} op_e;

  // One table row where rnd draws a random value and keep ORs in the shadow
  typedef struct {
    string     name;
    op_e       op;
    bit        rnd;
    bit        keep;
    lc_value_t value;
    lc_tx_t    tx;
  } row_t;

  logic      clk_i;
  logic      rst_ni;
  logic      lci_en_i;
  logic      lc_req_i;
  lc_tx_t    escalate_en_i;
  lc_value_t lc_data_i;
  logic      lc_ack_o;
  logic      lc_err_o;
  otp_err_e  error_o;
  logic      fsm_err_o;
  logic      lci_idle_o;

  // Reference copy of the partition fuses
  lc_value_t shadow;
  row_t      rows [8];

  otp_lci_top u_otp_lci_top (
    .clk_i, .rst_ni, .lci_en_i, .lc_req_i, .escalate_en_i, .lc_data_i,
    .lc_ack_o, .lc_err_o, .error_o, .fsm_err_o, .lci_idle_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_err(string name, otp_err_e exp, otp_err_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %s, actual %s", name, exp.name(), act.name());
      $display("Test failed");
      $fatal(1, "error code mismatch");
    end
  endtask

  // Pair is {ack, err}
  task automatic check_ack(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected ack/err %b, actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "ack mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  // Fresh reset also blanks the macro, so the shadow starts over
  task automatic enable_dut(string name);
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    lci_en_i      <= 1'b0;
    lc_req_i      <= 1'b0;
    escalate_en_i <= LcTxOff;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    shadow = '0;
    @(negedge clk_i);
    check_bit({name, " idle before enable"}, 1'b0, lci_idle_o);
    check_err({name, " error after reset"}, NoError, error_o);
    @(posedge clk_i);
    lci_en_i <= 1'b1;
    // Watchdog bounds this wait
    do @(negedge clk_i); while (!lci_idle_o);
  endtask

  // Requests held for 50 cycles must never be acknowledged
  task automatic check_locked(string name);
    @(posedge clk_i);
    lc_data_i <= '1;
    lc_req_i  <= 1'b1;
    repeat (50) begin
      @(negedge clk_i);
      check_bit({name, " no ack when locked"}, 1'b0, lc_ack_o);
    end
    @(posedge clk_i);
    lc_req_i <= 1'b0;
  endtask

  task automatic run_transition(string name, lc_value_t value);
    logic exp_fail;
    // Fails if any programmed bit would have to be cleared
    exp_fail = |(shadow & ~value);
    @(posedge clk_i);
    lc_data_i <= value;
    lc_req_i  <= 1'b1;
    // Request is sampled on the next edge and the FSM leaves idle
    @(posedge clk_i);
    @(negedge clk_i);
    check_bit({name, " busy while writing"}, 1'b0, lci_idle_o);
    do @(negedge clk_i); while (!lc_ack_o);
    check_ack(name, {1'b1, exp_fail}, {lc_ack_o, lc_err_o});
    @(posedge clk_i);
    lc_req_i <= 1'b0;
    shadow   = shadow | value;
    @(negedge clk_i);
    check_bit({name, " ack is one cycle"}, 1'b0, lc_ack_o);
    check_err(name, exp_fail ? MacroWriteBlankError : NoError, error_o);
    check_bit({name, " idle after ack"}, 1'b1, lci_idle_o);
    if (exp_fail) begin
      check_locked(name);
    end
  endtask

  task automatic escalate_dut(string name, lc_tx_t tx);
    enable_dut(name);
    @(posedge clk_i);
    escalate_en_i <= tx;
    @(negedge clk_i);
    check_bit({name, " fsm_err on escalation"}, 1'b1, fsm_err_o);
    @(posedge clk_i);
    escalate_en_i <= LcTxOff;
    @(negedge clk_i);
    check_err(name, FsmStateError, error_o);
    check_bit({name, " fsm_err after release"}, 1'b0, fsm_err_o);
    check_locked(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lc_value_t value;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    lc_req_i      = 1'b0;
    escalate_en_i = LcTxOff;
    lc_data_i     = '0;
    shadow        = '0;
    void'($urandom(1055));

    rows[0] = '{"enable_blank", OpEnable, 1'b0, 1'b0, '0, LcTxOff};
    rows[1] = '{"first_random", OpTransition, 1'b1, 1'b0, '0, LcTxOff};
    rows[2] = '{"add_bits_a", OpTransition, 1'b1, 1'b1, '0, LcTxOff};
    rows[3] = '{"add_bits_b", OpTransition, 1'b1, 1'b1, '0, LcTxOff};
    rows[4] = '{"add_bits_c", OpTransition, 1'b1, 1'b1, '0, LcTxOff};
    rows[5] = '{"clear_bits", OpTransition, 1'b0, 1'b0, '0, LcTxOff};
    rows[6] = '{"escalate_on", OpEscalate, 1'b0, 1'b0, '0, LcTxOn};
    rows[7] = '{"escalate_loose", OpEscalate, 1'b0, 1'b0, '0, 4'b0000};

    foreach (rows[i]) begin
      case (rows[i].op)
        OpEnable: enable_dut(rows[i].name);
        OpTransition: begin
          value = rows[i].value;
          if (rows[i].rnd) begin
            value = {$urandom(), $urandom()};
          end
          if (rows[i].keep) begin
            value = value | shadow;
          end
          run_transition(rows[i].name, value);
        end
        default: escalate_dut(rows[i].name, rows[i].tx);
      endcase
    end

    $display("Test completed successfully");
    $finish;
  end

  // Watchdog allows 100 cycles per table row
  initial begin
    repeat (100 * $size(rows)) @(posedge clk_i);
    $display("Timeout: the tests did not finish in the allowed number of cycles");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- otp_lci_top.sv
module otp_lci_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  input  logic                   lc_req_i,
  input  otp_lci_pkg::lc_tx_t    escalate_en_i,
  input  otp_lci_pkg::lc_value_t lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  output otp_lci_pkg::otp_err_e  error_o,
  output logic                   fsm_err_o,
  output logic                   lci_idle_o
);

  import otp_lci_pkg::*;

  // Interface to macro link
  logic        otp_req;
  otp_wr_req_t otp_wr;
  logic        otp_gnt;
  logic        otp_rvalid;
  otp_err_e    otp_err;

  // Life cycle programming FSM
  otp_lci u_otp_lci (
    .clk_i,
    .rst_ni,
    .lci_en_i,
    .lc_req_i,
    .escalate_en_i,
    .lc_data_i,
    .lc_ack_o,
    .lc_err_o,
    .error_o,
    .fsm_err_o,
    .lci_idle_o,
    .otp_req_o    (otp_req),
    .otp_wr_o     (otp_wr),
    .otp_gnt_i    (otp_gnt),
    .otp_rvalid_i (otp_rvalid),
    .otp_err_i    (otp_err)
  );

  // Behavioral fuse array
  otp_macro u_otp_macro (
    .clk_i,
    .rst_ni,
    .req_i     (otp_req),
    .wr_i      (otp_wr),
    .gnt_o     (otp_gnt),
    .rvalid_o  (otp_rvalid),
    .rsp_err_o (otp_err)
  );

endmodule

//--- otp_lci.sv
module otp_lci (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Lets the FSM leave reset state
  input  logic                     lci_en_i,
  // Requester side
  input  logic                     lc_req_i,
  input  otp_lci_pkg::lc_tx_t      escalate_en_i,
  input  otp_lci_pkg::lc_value_t   lc_data_i,
  output logic                     lc_ack_o,
  output logic                     lc_err_o,
  // Status toward error and alert logic
  output otp_lci_pkg::otp_err_e    error_o,
  output logic                     fsm_err_o,
  output logic                     lci_idle_o,
  // OTP macro side
  output logic                     otp_req_o,
  output otp_lci_pkg::otp_wr_req_t otp_wr_o,
  input  logic                     otp_gnt_i,
  input  logic                     otp_rvalid_i,
  input  otp_lci_pkg::otp_err_e    otp_err_i
);

  import otp_lci_pkg::*;

  lci_state_e state_d, state_q;
  otp_err_e   error_d, error_q;

  // Redundant word counter with one copy up and one copy down
  logic                cnt_clr;
  logic                cnt_en;
  logic                cnt_err;
  logic [CntWidth-1:0] cnt_up_q;
  logic [CntWidth-1:0] cnt_dn_q;
  logic [CntWidth-1:0] cnt_sum;

  // Partition value split into native words
  otp_word_t [LcPartWords-1:0] lc_words;

  assign lc_words = lc_data_i;
  assign error_o  = error_q;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    error_d    = error_q;
    cnt_clr    = 1'b0;
    cnt_en     = 1'b0;
    lci_idle_o = 1'b1;
    otp_req_o  = 1'b0;
    lc_ack_o   = 1'b0;
    lc_err_o   = 1'b0;
    fsm_err_o  = 1'b0;

    case (state_q)
      // Hold here until the interface is enabled
      ResetSt: begin
        lci_idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Wait for a transition request
      IdleSt: begin
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Present the current word until the macro grants it
      WriteSt: begin
        lci_idle_o = 1'b0;
        otp_req_o  = 1'b1;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response of the outstanding word
      WriteWaitSt: begin
        lci_idle_o = 1'b0;
        if (otp_rvalid_i) begin
          // Keep the failing code but still burn the remaining words
          if (otp_err_i != NoError) begin
            error_d = otp_err_i;
          end
          if (cnt_up_q == LcLastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failed word ends in the terminal state
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal state with the partition locked
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Illegal encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation or a counter fault overrides everything
    if (lc_tx_active(escalate_en_i) || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Word counter and write data
  ////////////////////////////////////////////////////////////

  // Both copies must always add up to the last word index
  assign cnt_sum = cnt_up_q + cnt_dn_q;
  assign cnt_err = (cnt_sum != LcLastWord);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_up_q <= '0;
      cnt_dn_q <= LcLastWord;
    end else if (cnt_clr) begin
      cnt_up_q <= '0;
      cnt_dn_q <= LcLastWord;
    end else if (cnt_en) begin
      cnt_up_q <= cnt_up_q + 1'b1;
      cnt_dn_q <= cnt_dn_q - 1'b1;
    end
  end

  // Word address is partition offset plus count
  assign otp_wr_o.addr  = otp_addr_t'(LcPartOffset) + otp_addr_t'(cnt_up_q);
  // Data only driven while requesting
  assign otp_wr_o.wdata = (state_q == WriteSt) ? lc_words[cnt_up_q] : '0;

  ////////////////////////////////////////////////////////////
  // State and error registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // All outputs resolved once out of reset
  a_outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({lc_ack_o, lc_err_o, error_o, fsm_err_o, lci_idle_o, otp_req_o, otp_wr_o}));

  // Macro responses only arrive for the word in flight
  a_rsp_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_rvalid_i |-> (state_q == WriteWaitSt));

  // Requester keeps its level up until the ack
  a_ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_o |-> lc_req_i);

endmodule

//--- otp_macro.sv
module otp_macro (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Write request, one word per grant
  input  logic                     req_i,
  input  otp_lci_pkg::otp_wr_req_t wr_i,
  output logic                     gnt_o,
  // Response two cycles after the grant
  output logic                     rvalid_o,
  output otp_lci_pkg::otp_err_e    rsp_err_o
);

  import otp_lci_pkg::*;

  // Fuse array where zero means blank
  otp_word_t mem_q [OtpDepth];

  // Two stage response pipe
  logic [1:0] vld_q;
  otp_err_e   err_s1_q;
  otp_err_e   err_s2_q;

  logic      busy;
  logic      wr_fire;
  logic      blank_err;
  otp_word_t old_word;

  ////////////////////////////////////////////////////////////
  // Grant and blank check
  ////////////////////////////////////////////////////////////

  // Single outstanding write so busy while a response is in flight
  assign busy    = |vld_q;
  assign gnt_o   = !busy;
  assign wr_fire = req_i && gnt_o;

  // A zero over a programmed one cannot be burnt
  assign old_word  = mem_q[wr_i.addr];
  assign blank_err = |(old_word & ~wr_i.wdata);

  ////////////////////////////////////////////////////////////
  // Fuse array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < OtpDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_fire) begin
      // Bits only ever go from 0 to 1
      mem_q[wr_i.addr] <= old_word | wr_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response delay line
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[0], wr_fire};
    end
  end

  // Error code travels alongside the valid bits
  always_ff @(posedge clk_i) begin
    err_s1_q <= blank_err ? MacroWriteBlankError : NoError;
    err_s2_q <= err_s1_q;
  end

  assign rvalid_o  = vld_q[1];
  assign rsp_err_o = vld_q[1] ? err_s2_q : NoError;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Fixed latency from grant to response
  a_rvalid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_fire |-> ##2 rvalid_o);

  // Requester waits for the response before the next word
  a_no_req_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy |-> !req_i);

endmodule

//--- otp_lci_pkg.sv
package otp_lci_pkg;

  ////////////////////////////////////////////////////////////
  // OTP geometry
  ////////////////////////////////////////////////////////////

  // Native OTP word and macro address widths
  localparam int OtpWidth     = 16;
  localparam int OtpAddrWidth = 6;
  localparam int OtpDepth     = 2 ** OtpAddrWidth;

  // Life cycle partition placement, in native words
  localparam int LcPartWords  = 4;
  localparam int LcPartOffset = 8;

  // Word counter covering the partition
  localparam int CntWidth = 2;
  localparam logic [CntWidth-1:0] LcLastWord = CntWidth'(LcPartWords - 1);

  ////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////

  typedef logic [OtpWidth-1:0] otp_word_t;
  typedef logic [OtpAddrWidth-1:0] otp_addr_t;

  // Full life cycle value, lowest word first
  typedef logic [LcPartWords*OtpWidth-1:0] lc_value_t;

  // Multibit escalation encoding
  typedef logic [3:0] lc_tx_t;
  localparam lc_tx_t LcTxOff = 4'b1010;
  localparam lc_tx_t LcTxOn  = 4'b0101;

  // Loose test, anything but Off counts as active
  function automatic logic lc_tx_active(lc_tx_t val);
    return val != LcTxOff;
  endfunction

  // Error codes from the macro and the interface FSM
  typedef enum logic [2:0] {
    NoError              = 3'd0,
    MacroWriteBlankError = 3'd1,
    MacroError           = 3'd2,
    FsmStateError        = 3'd3
  } otp_err_e;

  // Interface FSM states
  typedef enum logic [2:0] {
    ResetSt     = 3'd0,
    IdleSt      = 3'd1,
    WriteSt     = 3'd2,
    WriteWaitSt = 3'd3,
    ErrorSt     = 3'd4
  } lci_state_e;

  // One word write toward the macro
  typedef struct packed {
    otp_addr_t addr;
    otp_word_t wdata;
  } otp_wr_req_t;

endpackage
